// ==== sources.f ====
verilog/arena_pkg.sv
verilog/frame_ram.sv
verilog/arena_timer.sv
verilog/game_fsm.sv
verilog/pixel_render.sv
verilog/arena_top.sv
sim/tb_arena.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing -Wno-fatal -j 0
TOP       := tb_arena
FILELIST  := sources.f
OBJ_DIR   := obj_dir
BIN_NAME  := Varena_top
BIN       := $(OBJ_DIR)/$(BIN_NAME)
LOG       := sim.log

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when the file list or a source changes
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(OBJ_DIR) -o $(BIN_NAME)

# pass only if the log holds the pass line
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_arena.sv ====
`timescale 1ns/1ps

module tb_arena;
	import arena_pkg::*;

	localparam int ARENA_W   = 640;
	localparam int ARENA_H   = 480;
	localparam int SPEED_DIV = 4;
	localparam int WORDS     = ARENA_W * ARENA_H / 2;
	// steering, wall run, trail run and head-on run
	localparam int MOVES     = 16 + ARENA_W / 4 + ARENA_W;
	// three sweeps plus 8 cycles per frame pulse
	localparam int LIMIT     = 3 * WORDS + MOVES * SPEED_DIV * 8 + 5000;

	logic         Clk, rst_n, frame_clk, start;
	dir_t         blue_dir, red_dir;
	coord_t       draw_x, draw_y;
	color_t       color_enum;
	game_status_t status;

	logic [31:0] lfsr;
	int          cycles = 0;
	// reference model of both bikes
	pos_t        bpos, rpos;
	dir_t        bhdg, rhdg;
	pos_t        blue_past[$];
	pos_t        red_past[$];

	arena_top #(.ARENA_W(ARENA_W), .ARENA_H(ARENA_H), .SPEED_DIV(SPEED_DIV)) u_dut (
		.Clk(Clk), .rst_n(rst_n), .frame_clk(frame_clk), .start(start),
		.blue_dir(blue_dir), .red_dir(red_dir), .draw_x(draw_x), .draw_y(draw_y),
		.color_enum(color_enum), .status(status)
	);

	always #10 Clk = ~Clk;

	always @(posedge Clk)
	begin
		cycles <= cycles + 1;
		if (cycles == LIMIT)
		begin
			$display("timeout, the game never reached the awaited state");
			$display("ERRORS FOUND");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic pos_t next_cell(pos_t p, dir_t d);
		int dx;
		int dy;
		dx = 0;
		dy = 0;
		case (d)
			DIR_UP:    dy = -1;
			DIR_DOWN:  dy = 1;
			DIR_LEFT:  dx = -1;
			default:   dx = 1;
		endcase
		return '{x: coord_t'(int'(p.x) + dx), y: coord_t'(int'(p.y) + dy)};
	endfunction

	// opposite request keeps the heading
	function automatic dir_t apply_turn(dir_t cur, dir_t req);
		logic reverse;
		reverse = (cur == DIR_UP && req == DIR_DOWN) || (cur == DIR_DOWN && req == DIR_UP)
			|| (cur == DIR_LEFT && req == DIR_RIGHT) || (cur == DIR_RIGHT && req == DIR_LEFT);
		return reverse ? cur : req;
	endfunction

	task automatic check_color(string name, color_t exp, color_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
			$display("ERRORS FOUND");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic check_state(string name, game_state_t exp, game_state_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s: expected %s, actual %s", name, exp.name(), act.name());
			$display("ERRORS FOUND");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic check_winner(string name, winner_t exp, winner_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s: expected %s, actual %s", name, exp.name(), act.name());
			$display("ERRORS FOUND");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic check_head(string name, pos_t exp, pos_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s: expected (%0d,%0d), actual (%0d,%0d)",
				name, exp.x, exp.y, act.x, act.y);
			$display("ERRORS FOUND");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// inputs change 2 ns after the edge
	task automatic next_cycle();
		@(posedge Clk);
		#2;
	endtask

	task automatic pulse_frame();
		frame_clk = 1'b1;
		next_cycle();
		frame_clk = 1'b0;
		repeat (7)
			next_cycle();
	endtask

	// SPEED_DIV frames per move and a wait for the FSM to settle
	task automatic run_move();
		repeat (SPEED_DIV)
			pulse_frame();
		while (!(status.state inside {PLAY, OVER}))
			next_cycle();
	endtask

	// render latency of two cycles
	task automatic expect_pixel(string name, int x, int y, color_t exp);
		draw_x = coord_t'(x);
		draw_y = coord_t'(y);
		next_cycle();
		next_cycle();
		check_color(name, exp, color_enum);
	endtask

	task automatic press_start();
		blue_dir = DIR_RIGHT;
		red_dir  = DIR_LEFT;
		start    = 1'b1;
		next_cycle();
		start    = 1'b0;
		check_state("start pulse", CLEAR, status.state);
		// whole sweep first
		while (status.state != PLAY)
			next_cycle();
		bpos = '{x: coord_t'(ARENA_W / 4), y: coord_t'(ARENA_H / 2)};
		rpos = '{x: coord_t'(3 * ARENA_W / 4), y: coord_t'(ARENA_H / 2)};
		bhdg = DIR_RIGHT;
		rhdg = DIR_LEFT;
		blue_past.delete();
		red_past.delete();
	endtask

	task automatic step_and_check(string name, dir_t bd, dir_t rd);
		blue_dir = bd;
		red_dir  = rd;
		bhdg     = apply_turn(bhdg, bd);
		rhdg     = apply_turn(rhdg, rd);
		blue_past.push_back(bpos);
		red_past.push_back(rpos);
		bpos = next_cell(bpos, bhdg);
		rpos = next_cell(rpos, rhdg);
		run_move();
		check_state(name, PLAY, status.state);
		check_head(name, bpos, status.blue_head);
		check_head(name, rpos, status.red_head);
	endtask

	// heads stay where they were on a crash
	task automatic crash_move(string name, dir_t bd, dir_t rd, winner_t who);
		blue_dir = bd;
		red_dir  = rd;
		run_move();
		check_state(name, OVER, status.state);
		check_winner(name, who, status.winner);
		check_head(name, bpos, status.blue_head);
		check_head(name, rpos, status.red_head);
	endtask

	task automatic after_reset();
		logic [31:0] rx;
		logic [31:0] ry;
		check_state("reset", IDLE, status.state);
		check_winner("reset", NONE, status.winner);
		repeat (8)
		begin
			take_bits(10, rx);
			take_bits(9, ry);
			expect_pixel("reset pixel", int'(rx % ARENA_W), int'(ry % ARENA_H), COLOR_EMPTY);
		end
	endtask

	task automatic start_placement();
		press_start();
		check_head("start blue", bpos, status.blue_head);
		check_head("start red", rpos, status.red_head);
		expect_pixel("blue head", bpos.x, bpos.y, COLOR_BLUE_HEAD);
		expect_pixel("red head", rpos.x, rpos.y, COLOR_RED_HEAD);
		// no trail beside the heads yet
		expect_pixel("blue right", int'(bpos.x) + 1, bpos.y, COLOR_EMPTY);
		expect_pixel("blue left", int'(bpos.x) - 1, bpos.y, COLOR_EMPTY);
		expect_pixel("red right", int'(rpos.x) + 1, rpos.y, COLOR_EMPTY);
		expect_pixel("red left", int'(rpos.x) - 1, rpos.y, COLOR_EMPTY);
	endtask

	task automatic steering();
		repeat (5)
			step_and_check("steer up", DIR_UP, DIR_LEFT);
		// blue asks to reverse while red turns down
		repeat (3)
			step_and_check("steer down", DIR_DOWN, DIR_DOWN);
		foreach (blue_past[i])
			expect_pixel("blue trail", blue_past[i].x, blue_past[i].y, COLOR_BLUE_TRAIL);
		// red row covers odd and even x
		foreach (red_past[i])
			expect_pixel("red trail", red_past[i].x, red_past[i].y, COLOR_RED_TRAIL);
	endtask

	task automatic wall_crash();
		int steps;
		// cells left of the blue head
		steps = bpos.x;
		repeat (steps)
			step_and_check("wall run", DIR_LEFT, DIR_DOWN);
		crash_move("wall crash", DIR_LEFT, DIR_DOWN, RED);
		expect_pixel("odd trail after crash", 1, bpos.y, COLOR_BLUE_TRAIL);
		expect_pixel("even trail after crash", 2, bpos.y, COLOR_BLUE_TRAIL);
		expect_pixel("blue head after crash", bpos.x, bpos.y, COLOR_BLUE_HEAD);
		expect_pixel("red trail after crash", red_past[red_past.size() - 1].x,
			red_past[red_past.size() - 1].y, COLOR_RED_TRAIL);
	endtask

	task automatic collisions();
		pos_t old_blue;
		pos_t old_red;
		old_blue = blue_past[blue_past.size() - 1];
		old_red  = red_past[red_past.size() - 1];
		press_start();
		expect_pixel("blue trail cleared", old_blue.x, old_blue.y, COLOR_EMPTY);
		expect_pixel("red trail cleared", old_red.x, old_red.y, COLOR_EMPTY);
		// red lifts one row and runs back past blue
		step_and_check("trail setup", DIR_RIGHT, DIR_UP);
		while (rpos.x > bpos.x)
			step_and_check("trail run", DIR_RIGHT, DIR_LEFT);
		// then drops into the blue trail
		crash_move("trail crash", DIR_RIGHT, DIR_DOWN, BLUE);
		press_start();
		// both meet on the middle cell
		while (next_cell(bpos, bhdg) != next_cell(rpos, rhdg))
			step_and_check("head-on run", DIR_RIGHT, DIR_LEFT);
		crash_move("head-on crash", DIR_RIGHT, DIR_LEFT, DRAW);
	endtask

	initial
	begin
		Clk       = 1'b0;
		rst_n     = 1'b0;
		frame_clk = 1'b0;
		start     = 1'b0;
		blue_dir  = DIR_RIGHT;
		red_dir   = DIR_LEFT;
		draw_x    = '0;
		draw_y    = '0;
		lfsr      = 32'h1fa8;
		repeat (3)
			@(posedge Clk);
		#2;
		rst_n = 1'b1;
		after_reset();
		start_placement();
		steering();
		wall_crash();
		collisions();
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== verilog/arena_top.sv ====
`timescale 1ns/1ps

module arena_top #(
	parameter int ARENA_W   = 640,
	parameter int ARENA_H   = 480,
	parameter int SPEED_DIV = 4
) (
	input  logic                    Clk,
	input  logic                    rst_n,
	input  logic                    frame_clk,
	input  logic                    start,
	input  arena_pkg::dir_t         blue_dir,
	input  arena_pkg::dir_t         red_dir,
	input  arena_pkg::coord_t       draw_x,
	input  arena_pkg::coord_t       draw_y,
	output arena_pkg::color_t       color_enum,
	output arena_pkg::game_status_t status
);
	import arena_pkg::*;

	// two pixels per word
	localparam int WORDS = ARENA_W * ARENA_H / 2;

	logic                     move_tick, clear_done, clear_run, play_run;
	logic [$clog2(WORDS)-1:0] clear_addr;
	ram_wr_t                  wr;
	pix_addr_t                probe_addr, scan_addr;
	frame_word_u              probe_word, scan_word;

	frame_ram #(.WORDS(WORDS)) u_ram (
		.Clk(Clk), .wr(wr), .clear_addr(clear_addr),
		.probe_addr(probe_addr), .scan_addr(scan_addr),
		.probe_word(probe_word), .scan_word(scan_word)
	);

	arena_timer #(.SPEED_DIV(SPEED_DIV), .WORDS(WORDS)) u_timer (
		.Clk(Clk), .rst_n(rst_n), .frame_clk(frame_clk),
		.clear_run(clear_run), .play_run(play_run), .clear_addr(clear_addr),
		.clear_done(clear_done), .move_tick(move_tick)
	);

	game_fsm #(.ARENA_W(ARENA_W), .ARENA_H(ARENA_H)) u_fsm (
		.Clk(Clk), .rst_n(rst_n), .start(start),
		.blue_dir(blue_dir), .red_dir(red_dir),
		.move_tick(move_tick), .clear_done(clear_done), .probe_word(probe_word),
		.clear_run(clear_run), .play_run(play_run), .wr(wr),
		.probe_addr(probe_addr), .status(status)
	);

	// heads come straight from the status word
	pixel_render #(.ARENA_W(ARENA_W)) u_render (
		.Clk(Clk), .rst_n(rst_n), .draw_x(draw_x), .draw_y(draw_y),
		.scan_word(scan_word), .blue_head(status.blue_head),
		.red_head(status.red_head), .show_heads(status.state),
		.scan_addr(scan_addr), .color_enum(color_enum)
	);

endmodule

// ==== verilog/pixel_render.sv ====
`timescale 1ns/1ps

module pixel_render #(
	parameter int ARENA_W = 640
) (
	input  logic                   Clk,
	input  logic                   rst_n,
	input  arena_pkg::coord_t      draw_x,
	input  arena_pkg::coord_t      draw_y,
	input  arena_pkg::frame_word_u scan_word,
	input  arena_pkg::pos_t        blue_head,
	input  arena_pkg::pos_t        red_head,
	input  arena_pkg::game_state_t show_heads,
	output arena_pkg::pix_addr_t   scan_addr,
	output arena_pkg::color_t      color_enum
);
	import arena_pkg::*;

	pos_t draw_pos;
	pos_t scan_pos;
	logic heads_on;

	assign draw_pos = '{x: draw_x, y: draw_y};

	// ram registers this address
	// word lands one cycle later
	assign scan_addr = pix_index(draw_pos, ARENA_W);

	// heads only once the bikes are placed
	assign heads_on = !(show_heads inside {IDLE, CLEAR});

	// position delayed to match the read
	// x parity rides along in scan_pos
	always_ff @(posedge Clk)
	begin
		scan_pos <= draw_pos;
	end

	// head overlay wins over the buffer
	// blue checked first
	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
			color_enum <= COLOR_EMPTY;
		else if (heads_on && scan_pos == blue_head)
			color_enum <= COLOR_BLUE_HEAD;
		else if (heads_on && scan_pos == red_head)
			color_enum <= COLOR_RED_HEAD;
		else
			color_enum <= pick_pixel(scan_word, scan_pos.x[0]);
	end

endmodule

// ==== verilog/game_fsm.sv ====
`timescale 1ns/1ps

module game_fsm #(
	parameter int ARENA_W = 640,
	parameter int ARENA_H = 480
) (
	input  logic                   Clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  arena_pkg::dir_t        blue_dir,
	input  arena_pkg::dir_t        red_dir,
	input  logic                   move_tick,
	input  logic                   clear_done,
	input  arena_pkg::frame_word_u probe_word,
	output logic                   clear_run,
	output logic                   play_run,
	output arena_pkg::ram_wr_t     wr,
	output arena_pkg::pix_addr_t   probe_addr,
	output arena_pkg::game_status_t status
);
	import arena_pkg::*;

	game_state_t state;
	winner_t     winner;
	pos_t        blue_head, red_head, blue_next, red_next;
	dir_t        blue_hdg, red_hdg;
	logic        probe_red, blue_hit, red_hit, blue_off, red_off;
	logic        same_cell, blue_crash, red_crash;
	pix_addr_t   red_addr_q;

	function automatic pos_t step(pos_t p, dir_t d);
		pos_t n;
		n = p;
		case (d)
			DIR_UP:    n.y = p.y - 1'b1;
			DIR_DOWN:  n.y = p.y + 1'b1;
			DIR_LEFT:  n.x = p.x - 1'b1;
			default:   n.x = p.x + 1'b1;
		endcase
		return n;
	endfunction

	// next step would leave the arena
	function automatic logic at_wall(pos_t p, dir_t d);
		logic hit;
		case (d)
			DIR_UP:    hit = p.y == '0;
			DIR_DOWN:  hit = p.y == coord_t'(ARENA_H - 1);
			DIR_LEFT:  hit = p.x == '0;
			default:   hit = p.x == coord_t'(ARENA_W - 1);
		endcase
		return hit;
	endfunction

	// reversal keeps the old heading
	function automatic dir_t steer(dir_t cur, dir_t req);
		return (req == dir_t'({cur[1], ~cur[0]})) ? cur : req;
	endfunction

	assign blue_next  = step(blue_head, blue_hdg);
	assign red_next   = step(red_head, red_hdg);
	assign blue_off   = at_wall(blue_head, blue_hdg);
	assign red_off    = at_wall(red_head, red_hdg);
	// red data is on the port during DECIDE
	assign red_hit    = pick_pixel(probe_word, red_next.x[0]) != COLOR_EMPTY;
	assign same_cell  = blue_next == red_next;
	assign blue_crash = blue_off || blue_hit || same_cell;
	assign red_crash  = red_off || red_hit || same_cell;

	// blue first, then the red address from the cycle before
	assign probe_addr = probe_red ? red_addr_q : pix_index(blue_next, ARENA_W);

	assign clear_run = state == CLEAR;
	assign play_run  = state inside {PLAY, PROBE, DECIDE, WRITE_BLUE, WRITE_RED};
	assign status    = '{state: state, winner: winner, blue_head: blue_head, red_head: red_head};

	always_comb
	begin
		wr = '0;
		case (state)
			CLEAR:
			begin
				wr.en    = 1'b1;
				wr.whole = 1'b1;
			end
			WRITE_BLUE:
			begin
				wr.en    = 1'b1;
				wr.addr  = pix_index(blue_head, ARENA_W);
				wr.color = COLOR_BLUE_TRAIL;
			end
			WRITE_RED:
			begin
				wr.en    = 1'b1;
				wr.addr  = pix_index(red_head, ARENA_W);
				wr.color = COLOR_RED_TRAIL;
			end
			default:
				wr.en = 1'b0;
		endcase
	end

	// probe results
	always_ff @(posedge Clk)
	begin
		if (state == PROBE && !probe_red)
			red_addr_q <= pix_index(red_next, ARENA_W);
		if (state == PROBE && probe_red)
			blue_hit <= pick_pixel(probe_word, blue_next.x[0]) != COLOR_EMPTY;
	end

	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= IDLE;
			winner    <= NONE;
			probe_red <= 1'b0;
			blue_head <= '0;
			red_head  <= '0;
			blue_hdg  <= DIR_RIGHT;
			red_hdg   <= DIR_LEFT;
		end
		else
		begin
			case (state)
				IDLE, OVER:
					if (start)
					begin
						state  <= CLEAR;
						winner <= NONE;
					end
				CLEAR:
					// place bikes, start cells go through the write states
					if (clear_done)
					begin
						blue_head <= '{x: coord_t'(ARENA_W / 4), y: coord_t'(ARENA_H / 2)};
						red_head  <= '{x: coord_t'(3 * ARENA_W / 4), y: coord_t'(ARENA_H / 2)};
						blue_hdg  <= DIR_RIGHT;
						red_hdg   <= DIR_LEFT;
						state     <= WRITE_BLUE;
					end
				PLAY:
					if (move_tick)
					begin
						blue_hdg  <= steer(blue_hdg, blue_dir);
						red_hdg   <= steer(red_hdg, red_dir);
						probe_red <= 1'b0;
						state     <= PROBE;
					end
				PROBE:
					// two cycles on one port
					if (!probe_red)
						probe_red <= 1'b1;
					else
					begin
						probe_red <= 1'b0;
						state     <= DECIDE;
					end
				DECIDE:
					if (blue_crash && red_crash)
					begin
						winner <= DRAW;
						state  <= OVER;
					end
					else if (blue_crash || red_crash)
					begin
						winner <= blue_crash ? RED : BLUE;
						state  <= OVER;
					end
					else
					begin
						blue_head <= blue_next;
						red_head  <= red_next;
						state     <= WRITE_BLUE;
					end
				WRITE_BLUE:
					state <= WRITE_RED;
				default:
					state <= PLAY;
			endcase
		end
	end

endmodule

// ==== verilog/arena_timer.sv ====
`timescale 1ns/1ps

module arena_timer #(
	parameter int SPEED_DIV = 4,
	parameter int WORDS     = 153600
) (
	input  logic                     Clk,
	input  logic                     rst_n,
	input  logic                     frame_clk,
	input  logic                     clear_run,
	input  logic                     play_run,
	output logic [$clog2(WORDS)-1:0] clear_addr,
	output logic                     clear_done,
	output logic                     move_tick
);
	localparam int DIV_W = (SPEED_DIV > 1) ? $clog2(SPEED_DIV) : 1;
	localparam int CAW   = $clog2(WORDS);

	logic [DIV_W-1:0] frame_cnt;
	logic             last_frame;

	// tick on the last frame of each group
	assign last_frame = frame_cnt == DIV_W'(SPEED_DIV - 1);
	assign move_tick  = play_run && frame_clk && last_frame;

	// last word of the sweep
	assign clear_done = clear_run && (clear_addr == CAW'(WORDS - 1));

	// frame divider, held at zero outside play
	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
			frame_cnt <= '0;
		else if (!play_run)
			frame_cnt <= '0;
		else if (frame_clk)
		begin
			if (last_frame)
				frame_cnt <= '0;
			else
				frame_cnt <= frame_cnt + 1'b1;
		end
	end

	// sweep index
	// sits at zero so the first clear cycle hits word 0
	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
			clear_addr <= '0;
		else if (!clear_run || clear_done)
			clear_addr <= '0;
		else
			clear_addr <= clear_addr + 1'b1;
	end

endmodule

// ==== verilog/frame_ram.sv ====
`timescale 1ns/1ps

module frame_ram #(
	parameter int WORDS = 153600
) (
	input  logic                     Clk,
	input  arena_pkg::ram_wr_t       wr,
	input  logic [$clog2(WORDS)-1:0] clear_addr,
	input  arena_pkg::pix_addr_t     probe_addr,
	input  arena_pkg::pix_addr_t     scan_addr,
	output arena_pkg::frame_word_u   probe_word,
	output arena_pkg::frame_word_u   scan_word
);
	import arena_pkg::*;

	frame_word_u mem [WORDS];

	// single write port
	// sweep uses its own word index
	always_ff @(posedge Clk)
	begin
		if (wr.en)
		begin
			if (wr.whole)
				mem[clear_addr].raw <= '0;
			else if (wr.addr[0])
				mem[wr.addr[18:1]].pixels.odd <= wr.color;
			else
				mem[wr.addr[18:1]].pixels.even <= wr.color;
		end
	end

	// two registered read ports
	// pixel index halved to word index
	always_ff @(posedge Clk)
	begin
		probe_word <= mem[probe_addr[18:1]];
		scan_word  <= mem[scan_addr[18:1]];
	end

endmodule

// ==== verilog/arena_pkg.sv ====
package arena_pkg;

	// bike heading, bit 0 flips for the opposite way
	typedef enum logic [1:0] {
		DIR_UP    = 2'b00,
		DIR_DOWN  = 2'b01,
		DIR_LEFT  = 2'b10,
		DIR_RIGHT = 2'b11
	} dir_t;

	typedef logic [3:0] color_t;
	typedef logic [9:0] coord_t;
	typedef logic [18:0] pix_addr_t;

	localparam color_t COLOR_EMPTY      = 4'd0;
	localparam color_t COLOR_BLUE_TRAIL = 4'd1;
	localparam color_t COLOR_RED_TRAIL  = 4'd2;
	localparam color_t COLOR_BLUE_HEAD  = 4'd3;
	localparam color_t COLOR_RED_HEAD   = 4'd4;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} pos_t;

	// two pixels per word, low nibble of each byte
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [3:0] pad_hi;
			color_t     odd;
			logic [3:0] pad_lo;
			color_t     even;
		} pixels;
	} frame_word_u;

	// whole set means zero the word at the sweep index
	typedef struct packed {
		logic      en;
		logic      whole;
		pix_addr_t addr;
		color_t    color;
	} ram_wr_t;

	typedef enum logic [2:0] {
		IDLE,
		CLEAR,
		PLAY,
		PROBE,
		DECIDE,
		WRITE_BLUE,
		WRITE_RED,
		OVER
	} game_state_t;

	typedef enum logic [1:0] {
		NONE,
		BLUE,
		RED,
		DRAW
	} winner_t;

	typedef struct packed {
		game_state_t state;
		winner_t     winner;
		pos_t        blue_head;
		pos_t        red_head;
	} game_status_t;

	// row major pixel index
	function automatic pix_addr_t pix_index(pos_t p, int unsigned width);
		return pix_addr_t'(p.y * width + p.x);
	endfunction

	// odd x sits in bits 11 to 8
	function automatic color_t pick_pixel(frame_word_u w, logic odd);
		return odd ? w.pixels.odd : w.pixels.even;
	endfunction

endpackage
